// ==== Bender.yml ====
package:
  name: uart_string_handle

sources:
  - logic/uart_str_pkg.sv
  - logic/uart_tx.sv
  - logic/uart_rx.sv
  - logic/str_frame_tx.sv
  - logic/str_frame_rx.sv
  - logic/uart_string_handle.sv
  - target: test
    files:
      - test/str_checker.sv
      - test/tb_uart_string_handle.sv

// ==== files.f ====
logic/uart_str_pkg.sv
logic/uart_tx.sv
logic/uart_rx.sv
logic/str_frame_tx.sv
logic/str_frame_rx.sv
logic/uart_string_handle.sv
test/str_checker.sv
test/tb_uart_string_handle.sv

// ==== logic/str_frame_rx.sv ====
/*
 * String receive deframer.
 * Waits for "&&", collects content until "&&" arrives in a row and
 * presents the string with its length, saturating at MAX_LEN.
 */
module str_frame_rx #(
	parameter int MAX_LEN = uart_str_pkg::DEF_MAX_LEN
) (
	input  logic                         sys_clk,
	input  logic                         sys_rst_n,
	input  logic [7:0]                   byte_data,
	input  logic                         byte_vld,
	output logic [8*MAX_LEN-1:0]         rx_string,
	output logic [$clog2(MAX_LEN+1)-1:0] rx_length,
	output logic                         rx_busy,
	output logic                         rx_done
);
	import uart_str_pkg::*;

	localparam int               LEN_W = $clog2(MAX_LEN + 1);
	localparam logic [LEN_W-1:0] MAX_L = LEN_W'(MAX_LEN);

	frx_state_t state;
	logic       is_delim;
	logic       is_other;

	assign is_delim = byte_vld && (byte_data == DELIM);
	assign is_other = byte_vld && (byte_data != DELIM);
	assign rx_busy  = (state == FRX_HEAD1) || (state == FRX_BODY) || (state == FRX_ESC);
	assign rx_done  = (state == FRX_FINISH);

	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			state     <= FRX_IDLE;
			rx_length <= '0;
		end else begin
			case (state)
				FRX_IDLE: if (is_delim)
					state <= FRX_HEAD1;
				FRX_HEAD1: begin
					if (is_delim) begin
						state     <= FRX_BODY;
						rx_length <= '0;  // New frame starts here.
					end else if (is_other) begin
						state <= FRX_IDLE;
					end
				end
				FRX_BODY: begin
					if (is_delim)
						state <= FRX_ESC;
					else if (is_other && rx_length != MAX_L)
						rx_length <= rx_length + 1'b1;
				end
				FRX_ESC: begin
					if (is_delim) begin
						state <= FRX_FINISH;
					end else if (is_other) begin
						// Lone delimiter, keep it and the byte after it.
						state     <= FRX_BODY;
						rx_length <= (rx_length >= MAX_L - 1'b1) ? MAX_L : rx_length + 2'd2;
					end
				end
				FRX_FINISH: state <= FRX_IDLE;
				default:    state <= FRX_IDLE;
			endcase
		end
	end

	always_ff @(posedge sys_clk) begin
		if (state == FRX_BODY && is_other && rx_length < MAX_L)
			rx_string[8 * rx_length +: 8] <= byte_data;
		if (state == FRX_ESC && is_other) begin
			if (rx_length < MAX_L)
				rx_string[8 * rx_length +: 8] <= DELIM;
			if (rx_length + 1 < MAX_LEN)
				rx_string[8 * (rx_length + 1) +: 8] <= byte_data;
		end
	end

	a_len_cap: assert property (@(posedge sys_clk) disable iff (!sys_rst_n)
		rx_length <= MAX_L)
		else $error("str_frame_rx: rx_length above MAX_LEN");

endmodule

// ==== logic/str_frame_tx.sv ====
/*
 * String transmit framer.
 * Latches a string and its length, then hands "&&", the content
 * bytes and "&&" to the byte transmitter one at a time.
 */
module str_frame_tx #(
	parameter int MAX_LEN = uart_str_pkg::DEF_MAX_LEN
) (
	input  logic                         sys_clk,
	input  logic                         sys_rst_n,
	input  logic [8*MAX_LEN-1:0]         tx_string,
	input  logic [$clog2(MAX_LEN+1)-1:0] tx_length,
	input  logic                         tx_req,
	input  logic                         byte_done,
	output logic [7:0]                   byte_data,
	output logic                         byte_req,
	output logic                         tx_busy,
	output logic                         tx_done
);
	import uart_str_pkg::*;

	localparam int LEN_W = $clog2(MAX_LEN + 1);

	ftx_state_t           state;
	logic [8*MAX_LEN-1:0] str_buf;
	logic [LEN_W-1:0]     len_buf;
	logic [LEN_W-1:0]     idx;      // Content byte being sent.
	logic                 start;

	assign tx_busy   = (state != FTX_IDLE) && (state != FTX_FINISH);
	assign tx_done   = (state == FTX_FINISH);
	assign start     = tx_req && (tx_length != '0) && !tx_busy;
	assign byte_data = (state == FTX_BODY) ? str_buf[8 * idx +: 8] : DELIM;

	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			state    <= FTX_IDLE;
			byte_req <= 1'b0;
			idx      <= '0;
		end else begin
			byte_req <= 1'b0;
			case (state)
				FTX_IDLE, FTX_FINISH: begin
					if (start) begin
						state    <= FTX_HEAD1;
						byte_req <= 1'b1;
						idx      <= '0;
					end else begin
						state <= FTX_IDLE;
					end
				end
				FTX_HEAD1: if (byte_done) begin
					state    <= FTX_HEAD2;
					byte_req <= 1'b1;
				end
				FTX_HEAD2: if (byte_done) begin
					state    <= FTX_BODY;  // Byte 0 goes out next.
					byte_req <= 1'b1;
				end
				FTX_BODY: if (byte_done) begin
					byte_req <= 1'b1;
					if (idx == len_buf - 1'b1)
						state <= FTX_TAIL1;
					else
						idx <= idx + 1'b1;
				end
				FTX_TAIL1: if (byte_done) begin
					state    <= FTX_TAIL2;
					byte_req <= 1'b1;
				end
				FTX_TAIL2: if (byte_done)
					state <= FTX_FINISH;
				default: state <= FTX_IDLE;
			endcase
		end
	end

	always_ff @(posedge sys_clk) begin
		if (start) begin
			str_buf <= tx_string;
			len_buf <= tx_length;
		end
	end

	// One request per state, each paced by the previous byte_done.
	a_req_single: assert property (@(posedge sys_clk) disable iff (!sys_rst_n)
		byte_req |=> !byte_req until byte_done)
		else $error("str_frame_tx: second byte_req before byte_done");
	a_done_pulse: assert property (@(posedge sys_clk) disable iff (!sys_rst_n)
		tx_done |=> !tx_done)
		else $error("str_frame_tx: tx_done longer than one cycle");

endmodule

// ==== logic/uart_rx.sv ====
/*
 * UART byte receiver, 8N1.
 * Synchronizes the line, samples each bit at mid-bit and strobes
 * byte_vld for every byte whose stop bit is high.
 */
module uart_rx #(
	parameter int CLK_HZ    = 50_000_000,
	parameter int BAUD_RATE = 115_200
) (
	input  logic       sys_clk,
	input  logic       sys_rst_n,
	input  logic       rx,
	output logic [7:0] byte_data,
	output logic       byte_vld
);
	localparam int               BIT_CYC  = CLK_HZ / BAUD_RATE;
	localparam int               CNT_W    = $clog2(BIT_CYC + 1);
	localparam logic [CNT_W-1:0] BIT_LAST = CNT_W'(BIT_CYC - 1);
	localparam logic [CNT_W-1:0] BIT_MID  = CNT_W'(BIT_CYC / 2);

	logic [2:0]       rx_sync;   // Two sync stages plus edge history.
	logic             line;
	logic             fall;
	logic             active;
	logic [CNT_W-1:0] baud_cnt;
	logic [3:0]       bit_cnt;   // 0 start, 1..8 data, 9 stop.
	logic             mid;
	logic [7:0]       shift;

	assign line = rx_sync[1];
	assign fall = rx_sync[2] && !rx_sync[1];
	assign mid  = active && (baud_cnt == BIT_MID);

	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n)
			rx_sync <= 3'b111;
		else
			rx_sync <= {rx_sync[1:0], rx};
	end

	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			active   <= 1'b0;
			baud_cnt <= '0;
			bit_cnt  <= '0;
			byte_vld <= 1'b0;
		end else begin
			byte_vld <= 1'b0;
			if (!active) begin
				if (fall) begin
					active   <= 1'b1;
					baud_cnt <= '0;
					bit_cnt  <= '0;
				end
			end else begin
				if (baud_cnt == BIT_LAST) begin
					baud_cnt <= '0;
					bit_cnt  <= bit_cnt + 4'd1;
				end else begin
					baud_cnt <= baud_cnt + 1'b1;
				end
				if (mid && bit_cnt == 4'd0 && line)
					active <= 1'b0;  // False start, back to idle.
				else if (mid && bit_cnt == 4'd9) begin
					active   <= 1'b0;
					byte_vld <= line;  // Low stop bit drops the byte.
				end
			end
		end
	end

	always_ff @(posedge sys_clk) begin
		if (mid && bit_cnt >= 4'd1 && bit_cnt <= 4'd8)
			shift <= {line, shift[7:1]};  // LSB arrives first.
		if (mid && bit_cnt == 4'd9 && line)
			byte_data <= shift;
	end

endmodule

// ==== logic/uart_str_pkg.sv ====
/*
 * String link shared definitions.
 * Frame delimiter, default string capacity and the one-hot
 * state encodings of the transmit framer and receive deframer.
 */
package uart_str_pkg;

	localparam logic [7:0] DELIM       = 8'h26;  // ASCII "&".
	localparam int         DEF_MAX_LEN = 16;     // Bytes per string.

	typedef enum logic [6:0] {
		FTX_IDLE   = 7'b000_0001,
		FTX_HEAD1  = 7'b000_0010,  // First leading delimiter.
		FTX_HEAD2  = 7'b000_0100,  // Second leading delimiter.
		FTX_BODY   = 7'b000_1000,  // Content bytes.
		FTX_TAIL1  = 7'b001_0000,  // First trailing delimiter.
		FTX_TAIL2  = 7'b010_0000,  // Second trailing delimiter.
		FTX_FINISH = 7'b100_0000
	} ftx_state_t;

	typedef enum logic [4:0] {
		FRX_IDLE   = 5'b0_0001,
		FRX_HEAD1  = 5'b0_0010,  // One delimiter seen.
		FRX_BODY   = 5'b0_0100,  // Collecting content.
		FRX_ESC    = 5'b0_1000,  // Delimiter inside content.
		FRX_FINISH = 5'b1_0000
	} frx_state_t;

endpackage

// ==== logic/uart_string_handle.sv ====
/*
 * UART string link top level.
 * Joins the transmit framer and the 8N2 byte transmitter, and the
 * 8N1 byte receiver and the receive deframer.
 */
module uart_string_handle #(
	parameter int CLK_HZ    = 50_000_000,
	parameter int BAUD_RATE = 115_200,
	parameter int MAX_LEN   = uart_str_pkg::DEF_MAX_LEN
) (
	input  logic                         sys_clk,
	input  logic                         sys_rst_n,
	input  logic [8*MAX_LEN-1:0]         tx_string,
	input  logic [$clog2(MAX_LEN+1)-1:0] tx_length,
	input  logic                         tx_req,
	input  logic                         uart_rx_port,
	output logic                         tx_busy,
	output logic                         tx_done,
	output logic [8*MAX_LEN-1:0]         rx_string,
	output logic [$clog2(MAX_LEN+1)-1:0] rx_length,
	output logic                         rx_busy,
	output logic                         rx_done,
	output logic                         uart_tx_port
);
	logic [7:0] tx_byte;        // Framer to transmitter.
	logic       tx_byte_req;
	logic       tx_byte_done;
	logic [7:0] rx_byte;        // Receiver to deframer.
	logic       rx_byte_vld;

	str_frame_tx #(.MAX_LEN(MAX_LEN)) i_frame_tx (
		.sys_clk   (sys_clk),
		.sys_rst_n (sys_rst_n),
		.tx_string (tx_string),
		.tx_length (tx_length),
		.tx_req    (tx_req),
		.byte_done (tx_byte_done),
		.byte_data (tx_byte),
		.byte_req  (tx_byte_req),
		.tx_busy   (tx_busy),
		.tx_done   (tx_done)
	);

	str_frame_rx #(.MAX_LEN(MAX_LEN)) i_frame_rx (
		.sys_clk   (sys_clk),
		.sys_rst_n (sys_rst_n),
		.byte_data (rx_byte),
		.byte_vld  (rx_byte_vld),
		.rx_string (rx_string),
		.rx_length (rx_length),
		.rx_busy   (rx_busy),
		.rx_done   (rx_done)
	);

	uart_tx #(.CLK_HZ(CLK_HZ), .BAUD_RATE(BAUD_RATE)) i_uart_tx (
		.sys_clk   (sys_clk),
		.sys_rst_n (sys_rst_n),
		.byte_data (tx_byte),
		.byte_req  (tx_byte_req),
		.tx        (uart_tx_port),
		.byte_done (tx_byte_done)
	);

	uart_rx #(.CLK_HZ(CLK_HZ), .BAUD_RATE(BAUD_RATE)) i_uart_rx (
		.sys_clk   (sys_clk),
		.sys_rst_n (sys_rst_n),
		.rx        (uart_rx_port),
		.byte_data (rx_byte),
		.byte_vld  (rx_byte_vld)
	);

endmodule

// ==== logic/uart_tx.sv ====
/*
 * UART byte transmitter, 8N2.
 * Sends a start bit, eight data bits LSB first and two stop bits,
 * then pulses byte_done at the end of the last stop bit.
 */
module uart_tx #(
	parameter int CLK_HZ    = 50_000_000,
	parameter int BAUD_RATE = 115_200
) (
	input  logic       sys_clk,
	input  logic       sys_rst_n,
	input  logic [7:0] byte_data,
	input  logic       byte_req,
	output logic       tx,
	output logic       byte_done
);
	localparam int               BIT_CYC  = CLK_HZ / BAUD_RATE;
	localparam int               CNT_W    = $clog2(BIT_CYC + 1);
	localparam logic [CNT_W-1:0] BIT_LAST = CNT_W'(BIT_CYC - 1);

	logic             busy;
	logic [CNT_W-1:0] baud_cnt;
	logic [3:0]       bit_cnt;   // 0 start, 1..8 data, 9..10 stop.
	logic [9:0]       shift;     // Remaining data and stop bits.
	logic             bit_end;

	assign bit_end = busy && (baud_cnt == BIT_LAST);

	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			busy      <= 1'b0;
			baud_cnt  <= '0;
			bit_cnt   <= '0;
			tx        <= 1'b1;  // Line idles high.
			byte_done <= 1'b0;
		end else begin
			byte_done <= 1'b0;
			if (!busy) begin
				if (byte_req) begin
					busy     <= 1'b1;
					baud_cnt <= '0;
					bit_cnt  <= '0;
					tx       <= 1'b0;  // Start bit.
				end
			end else if (bit_end) begin
				baud_cnt <= '0;
				if (bit_cnt == 4'd10) begin
					busy      <= 1'b0;
					byte_done <= 1'b1;
					tx        <= 1'b1;
				end else begin
					bit_cnt <= bit_cnt + 4'd1;
					tx      <= shift[0];
				end
			end else begin
				baud_cnt <= baud_cnt + 1'b1;
			end
		end
	end

	always_ff @(posedge sys_clk) begin
		if (!busy && byte_req)
			shift <= {2'b11, byte_data};  // Stop bits ride above the data.
		else if (bit_end)
			shift <= {1'b1, shift[9:1]};
	end

	// The framer must wait for byte_done before the next request.
	a_no_req_busy: assert property (@(posedge sys_clk) disable iff (!sys_rst_n)
		byte_req |-> !busy)
		else $error("uart_tx: byte_req while a byte is on the line");

endmodule

// ==== test/str_checker.sv ====
/*
 * Frame checker for the UART string link testbench.
 * Compares each received string with the posted expectation,
 * watches the tx_busy and tx_done rules and reports per test.
 */
module str_checker #(
	parameter int MAX_LEN = 16
) (
	input  logic                         sys_clk,
	input  logic                         sys_rst_n,
	input  logic [$clog2(MAX_LEN+1)-1:0] tx_length,
	input  logic                         tx_req,
	input  logic                         tx_busy,
	input  logic                         tx_done,
	input  logic [8*MAX_LEN-1:0]         rx_string,
	input  logic [$clog2(MAX_LEN+1)-1:0] rx_length,
	input  logic                         rx_busy,
	input  logic                         rx_done,
	input  logic                         uart_tx_port,
	input  logic [8*MAX_LEN-1:0]         exp_string,
	input  logic [$clog2(MAX_LEN+1)-1:0] exp_length,
	input  logic                         exp_post,
	input  logic                         test_end,
	input  int                           test_id,
	output int                           err_cnt,
	output int                           frame_cnt,
	output int                           test_cnt
);
	logic [8*MAX_LEN-1:0]         want_str;
	logic [$clog2(MAX_LEN+1)-1:0] want_len;
	logic                         pending;        // Posted frame not yet received.
	logic                         reset_checked;
	logic                         prev_busy;
	logic                         prev_done;
	logic                         prev_start;
	logic                         prev_rx_busy;
	int                           err_mark;       // Errors before this test.

	task automatic flag_error(input string msg);
		err_cnt++;
		$display("FAIL %0t: %s", $time, msg);
	endtask

	task automatic report_missing();
		err_cnt++;
		pending = 1'b0;
		$display("Expected frame never completed, no rx_done by %0t", $time);
	endtask

	task automatic check_frame();
		int bad;
		bad = -1;
		frame_cnt++;
		if (!pending) begin
			err_cnt++;
			$display("Unexpected rx_done at %0t while no frame was sent", $time);
		end else begin
			pending = 1'b0;
			// Lowest mismatching byte wins.
			for (int i = MAX_LEN - 1; i >= 0; i--)
				if (i < want_len && rx_string[8*i +: 8] != want_str[8*i +: 8])
					bad = i;
			if (rx_length != want_len)
				flag_error($sformatf("rx_length %0d, expected %0d", rx_length, want_len));
			else if (bad >= 0)
				flag_error($sformatf("rx byte %0d is %h, expected %h", bad,
					rx_string[8*bad +: 8], want_str[8*bad +: 8]));
		end
	endtask

	always @(posedge sys_clk) begin
		if (!sys_rst_n) begin
			err_cnt       = 0;
			frame_cnt     = 0;
			test_cnt      = 0;
			err_mark      = 0;
			pending       = 1'b0;
			reset_checked = 1'b0;
			prev_busy     = 1'b0;
			prev_done     = 1'b0;
			prev_start    = 1'b0;
			prev_rx_busy  = 1'b0;
		end else begin
			if (!reset_checked) begin
				reset_checked = 1'b1;  // First edge out of reset.
				if (!uart_tx_port || tx_busy || tx_done || rx_busy || rx_done
						|| rx_length != '0)
					flag_error("outputs not at their reset values");
			end
			if (tx_busy && !prev_busy && !prev_start)
				flag_error("tx_busy rose without a valid tx_req");
			if (tx_done && prev_done)
				flag_error("tx_done longer than one cycle");
			if (prev_busy && !tx_busy && !tx_done)
				flag_error("tx_busy fell without tx_done");
			if (tx_done && !prev_busy)
				flag_error("tx_done without a frame in flight");
			if (rx_done && (rx_busy || !prev_rx_busy))
				flag_error("rx_busy not high up to rx_done");
			if (exp_post) begin
				if (pending)
					report_missing();
				want_str = exp_string;
				want_len = exp_length;
				pending  = 1'b1;
			end
			if (rx_done)
				check_frame();
			if (test_end) begin
				if (pending)
					report_missing();
				test_cnt++;
				$display("test %0d: %s", test_id, (err_cnt == err_mark) ? "ok" : "errors");
				err_mark = err_cnt;
			end
			prev_busy    = tx_busy;
			prev_done    = tx_done;
			prev_start   = tx_req && (tx_length != '0);
			prev_rx_busy = rx_busy;
		end
	end

endmodule

// ==== test/tb_uart_string_handle.sv ====
/*
 * Testbench for the UART string link.
 * Sends loopback and bench-driven frames, derives each expected
 * string from the bytes on the line and posts it to the checker.
 */
module tb_uart_string_handle;
	import uart_str_pkg::*;

	localparam int CLK_HZ    = 1_000_000;
	localparam int BAUD_RATE = 100_000;
	localparam int MAX_LEN   = 16;
	localparam int LEN_W     = $clog2(MAX_LEN + 1);
	localparam int BIT_CYC   = CLK_HZ / BAUD_RATE;
	// Bytes per frame of every test, four delimiters each.
	localparam int FRAME_BYTES = (0+4) + (1+4) + (5+4) + (16+4) + (0+4) + (3+4)
		+ (5+4) + (20+4) + (8+4);
	localparam int RUN_LIMIT = FRAME_BYTES * 11 * BIT_CYC * 12 / 10;

	logic                 sys_clk;
	logic                 sys_rst_n;
	logic [8*MAX_LEN-1:0] tx_string;
	logic [LEN_W-1:0]     tx_length;
	logic                 tx_req;
	logic                 uart_rx_port;
	logic                 tx_busy;
	logic                 tx_done;
	logic [8*MAX_LEN-1:0] rx_string;
	logic [LEN_W-1:0]     rx_length;
	logic                 rx_busy;
	logic                 rx_done;
	logic                 uart_tx_port;
	logic [8*MAX_LEN-1:0] exp_string;
	logic [LEN_W-1:0]     exp_length;
	logic                 exp_post;
	logic                 test_end;
	int                   test_id;
	int                   err_cnt;
	int                   frame_cnt;
	int                   test_cnt;
	logic                 loop_sel;   // High routes the DUT output back in.
	logic                 drv_line;
	logic [31:0]          rng_state;
	logic [7:0]           line_q[$];  // Bytes of one test on the line.
	int                   tx_done_cnt = 0;
	int                   rx_done_cnt = 0;
	int                   tx_mark;
	int                   rx_mark;
	int                   cycle_cnt = 0;

	assign uart_rx_port = loop_sel ? uart_tx_port : drv_line;

	uart_string_handle #(
		.CLK_HZ    (CLK_HZ),
		.BAUD_RATE (BAUD_RATE),
		.MAX_LEN   (MAX_LEN)
	) i_uart_string_handle (
		.sys_clk      (sys_clk),
		.sys_rst_n    (sys_rst_n),
		.tx_string    (tx_string),
		.tx_length    (tx_length),
		.tx_req       (tx_req),
		.uart_rx_port (uart_rx_port),
		.tx_busy      (tx_busy),
		.tx_done      (tx_done),
		.rx_string    (rx_string),
		.rx_length    (rx_length),
		.rx_busy      (rx_busy),
		.rx_done      (rx_done),
		.uart_tx_port (uart_tx_port)
	);

	str_checker #(.MAX_LEN(MAX_LEN)) i_str_checker (.*);

	always #50 sys_clk = ~sys_clk;

	always @(posedge sys_clk) begin
		cycle_cnt++;
		if (tx_done)
			tx_done_cnt++;
		if (rx_done)
			rx_done_cnt++;
		if (cycle_cnt >= RUN_LIMIT) begin
			$display("Timeout: run stopped after %0d cycles", cycle_cnt);
			$display("Done: errors found");
			$finish;
		end
	end

	function automatic logic [31:0] xorshift32(input logic [31:0] x);
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	// Random content byte, never a delimiter.
	function automatic logic [7:0] rand_byte();
		rng_state = xorshift32(rng_state);
		return (rng_state[7:0] == DELIM) ? 8'h41 : rng_state[7:0];
	endfunction

	function automatic void append(inout logic [8*MAX_LEN-1:0] str, inout int len,
			input logic [7:0] b);
		if (len < MAX_LEN) begin
			str[8*len +: 8] = b;
			len++;
		end
	endfunction

	// Expected string and length of the frame carried by line_q.
	function automatic void deframe(output logic [8*MAX_LEN-1:0] str, output int len);
		int         mode;  // 0 hunt, 1 one "&", 2 content, 3 "&" in content, 4 done.
		logic [7:0] b;
		str  = '0;
		len  = 0;
		mode = 0;
		foreach (line_q[i]) begin
			b = line_q[i];
			case (mode)
				0: if (b == DELIM) mode = 1;
				1: begin
					mode = (b == DELIM) ? 2 : 0;
					len  = 0;
				end
				2: begin
					if (b == DELIM)
						mode = 3;
					else
						append(str, len, b);
				end
				3: begin
					if (b == DELIM) begin
						mode = 4;
					end else begin
						append(str, len, DELIM);  // Lone "&" keeps its partner.
						append(str, len, b);
						mode = 2;
					end
				end
				default: ;
			endcase
		end
	endfunction

	task automatic step(input int n);
		repeat (n) @(posedge sys_clk);
		#10;
	endtask

	task automatic send_byte(input logic [7:0] b);
		drv_line = 1'b0;
		step(BIT_CYC);
		for (int i = 0; i < 8; i++) begin
			drv_line = b[i];
			step(BIT_CYC);
		end
		drv_line = 1'b1;
		step(BIT_CYC);
	endtask

	task automatic post_expected();
		logic [8*MAX_LEN-1:0] str;
		int                   len;
		deframe(str, len);
		exp_string = str;
		exp_length = LEN_W'(len);
		exp_post   = 1'b1;
		tx_mark    = tx_done_cnt;
		rx_mark    = rx_done_cnt;
		step(1);
		exp_post   = 1'b0;
	endtask

	task automatic wait_frame(input logic with_tx, input int bytes);
		int limit;
		limit = (bytes + 4) * 11 * BIT_CYC + 100;
		while (limit > 0 && (rx_done_cnt == rx_mark ||
				(with_tx && tx_done_cnt == tx_mark))) begin
			step(1);
			limit--;
		end
	endtask

	task automatic loop_frame(input int n, input logic hit_busy);
		logic [7:0] b;
		line_q    = {DELIM, DELIM};
		tx_string = '0;
		for (int i = 0; i < n; i++) begin
			b = rand_byte();
			tx_string[8*i +: 8] = b;
			line_q.push_back(b);
		end
		line_q.push_back(DELIM);
		line_q.push_back(DELIM);
		post_expected();
		tx_length = LEN_W'(n);
		tx_req    = 1'b1;
		step(1);
		tx_req    = 1'b0;
		if (hit_busy) begin
			step(3 * BIT_CYC);
			tx_string = ~tx_string;  // Must not reach the line.
			tx_length = LEN_W'(MAX_LEN);
			tx_req    = 1'b1;
			step(1);
			tx_req    = 1'b0;
		end
		wait_frame(1'b1, n);
	endtask

	task automatic drive_frame();
		post_expected();
		foreach (line_q[i])
			send_byte(line_q[i]);
		wait_frame(1'b0, line_q.size());
	endtask

	task automatic end_test(input int n);
		test_id  = n;
		test_end = 1'b1;
		step(1);
		test_end = 1'b0;
		step(2);
	endtask

	initial begin
		sys_clk    = 1'b0;
		sys_rst_n  = 1'b0;
		tx_string  = '0;
		tx_length  = '0;
		tx_req     = 1'b0;
		loop_sel   = 1'b1;
		drv_line   = 1'b1;
		exp_string = '0;
		exp_length = '0;
		exp_post   = 1'b0;
		test_end   = 1'b0;
		test_id    = 0;
		rng_state  = 32'd41426;
		step(8);
		sys_rst_n = 1'b1;
		step(2);
		end_test(1);

		loop_frame(1, 1'b0);
		loop_frame(5, 1'b0);
		loop_frame(MAX_LEN, 1'b0);
		end_test(2);

		tx_length = '0;  // Zero length is ignored.
		tx_req    = 1'b1;
		step(1);
		tx_req    = 1'b0;
		step(20);
		loop_frame(3, 1'b1);
		step(20);
		end_test(3);

		loop_sel = 1'b0;
		line_q   = {DELIM, DELIM, 8'h61, 8'h62, DELIM, 8'h63, 8'h64, DELIM, DELIM};
		drive_frame();
		end_test(4);

		line_q = {DELIM, DELIM};
		repeat (MAX_LEN + 4) line_q.push_back(rand_byte());
		line_q.push_back(DELIM);
		line_q.push_back(DELIM);
		drive_frame();
		end_test(5);

		// Stray bytes and a lone "&" ahead of a proper frame.
		line_q = {rand_byte(), rand_byte(), DELIM, rand_byte(), DELIM, DELIM};
		repeat (4) line_q.push_back(rand_byte());
		line_q.push_back(DELIM);
		line_q.push_back(DELIM);
		drive_frame();
		end_test(6);

		step(5);
		$display("Summary: %0d tests, %0d frames checked, %0d errors",
			test_cnt, frame_cnt, err_cnt);
		if (err_cnt == 0)
			$display("Done: no errors");
		else
			$display("Done: errors found");
		$finish;
	end

endmodule
